/* source/mipsCore_defs.svh */
`ifndef MIPSCORE_DEFS_SVH
`define MIPSCORE_DEFS_SVH

`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32
`define RESET_VECTOR    32'h0000_0000

// Opcodes
`define OP_RTYPE  6'b000000
`define OP_ADDI   6'b001000
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_J      6'b000010

// R-format function codes
`define FN_ADD    6'b100000
`define FN_ADDU   6'b100001
`define FN_SUB    6'b100010
`define FN_SUBU   6'b100011
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_NOR    6'b100111
`define FN_SLT    6'b101010
`define FN_SLTU   6'b101011

`endif

/* source/mipsPkg.sv */
package mipsPkg;

   typedef enum logic [3:0] {
      aluAdd  = 4'b0000,
      aluSub  = 4'b0001,
      aluSlt  = 4'b0010,
      aluSltu = 4'b0011,
      aluAnd  = 4'b0100,
      aluOr   = 4'b0101,
      aluXor  = 4'b0110,
      aluNor  = 4'b0111,
      aluAddu = 4'b1000,
      aluSubu = 4'b1001,
      aluLui  = 4'b1011
   } aluOpT;

   typedef enum logic [4:0] {
      stReset, stFetch1, stFetch2, stFetch3, stDecode,
      stExR, stExI,
      stLw1, stLw2, stLw3, stLw4,
      stSw1, stSw2, stSw3,
      stBra1, stBra2,
      stJump
   } ctrlStateT;

   // Datapath mux selects
   typedef enum logic {pcAlu, pcJump} pcSrcT;
   typedef enum logic [1:0] {addrPc, addrAlu, addrJump} addrSrcT;
   typedef enum logic {aluAPc, aluAReg} aluASelT;
   typedef enum logic [1:0] {aluBReg, aluBFour, aluBImm, aluBImmSh} aluBSelT;
   typedef enum logic {dstRt, dstRd} regDstT;
   typedef enum logic {wbAlu, wbMdr} wbSrcT;

endpackage

/* source/ctrlIf.sv */
`timescale 1ns/10ps

interface ctrlIf;
   import mipsPkg::*;

   // Controls toward the datapath
   logic    pcWrite;
   pcSrcT   pcSrc;
   logic    irWrite;
   logic    abWrite;
   logic    mdrWrite;
   logic    marWrite;
   addrSrcT addrSrc;
   logic    rfWrite;
   regDstT  regDst;
   wbSrcT   wbSrc;
   aluASelT aluSelA;
   aluBSelT aluSelB;
   aluOpT   aluOp;
   logic    signExt;
   logic    setMemRead;
   logic    clrMemRead;
   logic    setMemWrite;

   // Status back to the FSM
   logic [5:0] opcode;
   logic [5:0] funct;
   logic       aluZero;

   modport controller (
      output pcWrite, pcSrc, irWrite, abWrite, mdrWrite, marWrite, addrSrc,
      output rfWrite, regDst, wbSrc, aluSelA, aluSelB, aluOp, signExt,
      output setMemRead, clrMemRead, setMemWrite,
      input  opcode, funct, aluZero
   );

   modport datapath (
      input  pcWrite, pcSrc, irWrite, abWrite, mdrWrite, marWrite, addrSrc,
      input  rfWrite, regDst, wbSrc, aluSelA, aluSelB, aluOp, signExt,
      input  setMemRead, clrMemRead, setMemWrite,
      output opcode, funct, aluZero
   );

endinterface

/* source/mipsAlu.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module mipsAlu (
   input  logic [`DATA_WIDTH-1:0] a,
   input  logic [`DATA_WIDTH-1:0] b,
   input  mipsPkg::aluOpT         op,
   output logic [`DATA_WIDTH-1:0] result,
   output logic                   zero
);
   import mipsPkg::*;

   logic [`DATA_WIDTH:0] signedDiff;
   logic [`DATA_WIDTH:0] unsignedDiff;

   // One extra bit so the sign never overflows
   assign signedDiff   = {a[`DATA_WIDTH-1], a} - {b[`DATA_WIDTH-1], b};
   assign unsignedDiff = {1'b0, a} - {1'b0, b};   // MSB is the borrow

   always_comb begin
      case (op)
         aluAdd, aluAddu:
            result = a + b;
         aluSub, aluSubu:
            result = unsignedDiff[`DATA_WIDTH-1:0];
         aluSlt:
            result = {{(`DATA_WIDTH-1){1'b0}}, signedDiff[`DATA_WIDTH]};
         aluSltu:
            result = {{(`DATA_WIDTH-1){1'b0}}, unsignedDiff[`DATA_WIDTH]};
         aluAnd:
            result = a & b;
         aluOr:
            result = a | b;
         aluXor:
            result = a ^ b;
         aluNor:
            result = ~(a | b);
         aluLui:
            result = b << 16;
         default:
            result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

/* source/regFile.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module regFile (
   input  logic                       clk,
   input  logic                       write,
   input  logic [`REG_ADDR_WIDTH-1:0] readAddr1,
   input  logic [`REG_ADDR_WIDTH-1:0] readAddr2,
   input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
   input  logic [`DATA_WIDTH-1:0]     writeData,
   output logic [`DATA_WIDTH-1:0]     readData1,
   output logic [`DATA_WIDTH-1:0]     readData2
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (write)
         regs[writeAddr] <= writeData;
   end

   // Register 0 is hardwired to zero on the read side
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* source/mipsDatapath.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module mipsDatapath (
   input  logic                   clk,
   input  logic                   reset,
   ctrlIf.datapath                ctrl,
   output logic [`DATA_WIDTH-1:0] memAddr,
   input  logic [`DATA_WIDTH-1:0] memReadData,
   output logic [`DATA_WIDTH-1:0] memWriteData,
   output logic                   memRead,
   output logic                   memWrite
);
   import mipsPkg::*;

   logic [`DATA_WIDTH-1:0] pc, ir, regA, regB, mdr, mar;
   logic [`DATA_WIDTH-1:0] rfData1, rfData2;
   logic [`DATA_WIDTH-1:0] aluA, aluB, aluResult;
   logic [`DATA_WIDTH-1:0] extImm, jumpTarget, rfWriteData;
   logic [`REG_ADDR_WIDTH-1:0] rfWriteAddr;

   // ==================================================
   // Control registers
   // ==================================================
   always_ff @(posedge clk) begin
      if (reset)
         pc <= `RESET_VECTOR;
      else if (ctrl.pcWrite)
         pc <= (ctrl.pcSrc == pcJump) ? jumpTarget : aluResult;
   end

   always_ff @(posedge clk) begin
      if (reset || ctrl.clrMemRead)
         memRead <= 1'b0;
      else if (ctrl.setMemRead)
         memRead <= 1'b1;

      if (reset || memWrite)   // One-cycle write pulse
         memWrite <= 1'b0;
      else if (ctrl.setMemWrite)
         memWrite <= 1'b1;
   end

   // ==================================================
   // Payload registers
   // ==================================================
   always_ff @(posedge clk) begin
      if (ctrl.irWrite)  ir  <= memReadData;
      if (ctrl.mdrWrite) mdr <= memReadData;
      if (ctrl.abWrite) begin
         regA <= rfData1;
         regB <= rfData2;
      end
      if (ctrl.marWrite) begin
         case (ctrl.addrSrc)
            addrAlu:  mar <= aluResult;
            addrJump: mar <= jumpTarget;
            default:  mar <= pc;
         endcase
      end
   end

   assign extImm     = ctrl.signExt ? {{16{ir[15]}}, ir[15:0]} : {16'b0, ir[15:0]};
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

   // Operand muxes
   assign aluA = (ctrl.aluSelA == aluAPc) ? pc : regA;

   always_comb begin
      case (ctrl.aluSelB)
         aluBFour:  aluB = 32'd4;
         aluBImm:   aluB = extImm;
         aluBImmSh: aluB = extImm << 2;
         default:   aluB = regB;
      endcase
   end

   assign rfWriteAddr = (ctrl.regDst == dstRd) ? ir[15:11] : ir[20:16];
   assign rfWriteData = (ctrl.wbSrc == wbMdr) ? mdr : aluResult;

   regFile u_regFile (
      .clk       (clk),
      .write     (ctrl.rfWrite),
      .readAddr1 (ir[25:21]),
      .readAddr2 (ir[20:16]),
      .writeAddr (rfWriteAddr),
      .writeData (rfWriteData),
      .readData1 (rfData1),
      .readData2 (rfData2)
   );

   mipsAlu u_alu (
      .a      (aluA),
      .b      (aluB),
      .op     (ctrl.aluOp),
      .result (aluResult),
      .zero   (ctrl.aluZero)
   );

   assign ctrl.opcode = ir[31:26];
   assign ctrl.funct  = ir[5:0];

   assign memAddr      = mar;
   assign memWriteData = regB;

endmodule

/* source/mipsController.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module mipsController (
   input  logic         clk,
   input  logic         reset,
   ctrlIf.controller    ctrl
);
   import mipsPkg::*;

   ctrlStateT state, nextState;
   logic      prepFetch;   // Final state of an instruction

   function automatic aluOpT rTypeOp(input logic [5:0] funct);
      case (funct)
         `FN_ADDU: return aluAddu;
         `FN_SUB:  return aluSub;
         `FN_SUBU: return aluSubu;
         `FN_AND:  return aluAnd;
         `FN_OR:   return aluOr;
         `FN_XOR:  return aluXor;
         `FN_NOR:  return aluNor;
         `FN_SLT:  return aluSlt;
         `FN_SLTU: return aluSltu;
         default:  return aluAdd;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (reset)
         state <= stReset;
      else
         state <= nextState;
   end

   // ==================================================
   // Next state and control decode
   // ==================================================
   always_comb begin
      nextState        = stFetch1;
      prepFetch        = 1'b0;
      ctrl.pcWrite     = 1'b0;
      ctrl.pcSrc       = pcAlu;
      ctrl.irWrite     = 1'b0;
      ctrl.abWrite     = 1'b0;
      ctrl.mdrWrite    = 1'b0;
      ctrl.marWrite    = 1'b0;
      ctrl.addrSrc     = addrPc;
      ctrl.rfWrite     = 1'b0;
      ctrl.regDst      = dstRt;
      ctrl.wbSrc       = wbAlu;
      ctrl.aluSelA     = aluAReg;
      ctrl.aluSelB     = aluBReg;
      ctrl.aluOp       = aluAdd;
      ctrl.signExt     = 1'b1;
      ctrl.setMemRead  = 1'b0;
      ctrl.clrMemRead  = 1'b0;
      ctrl.setMemWrite = 1'b0;

      case (state)
         stFetch1: nextState = stFetch2;
         stFetch2: nextState = stFetch3;
         stFetch3: begin   // IR load and PC + 4
            ctrl.irWrite    = 1'b1;
            ctrl.pcWrite    = 1'b1;
            ctrl.clrMemRead = 1'b1;
            ctrl.aluSelA    = aluAPc;
            ctrl.aluSelB    = aluBFour;
            nextState       = stDecode;
         end
         stDecode: begin
            ctrl.abWrite = 1'b1;
            case (ctrl.opcode)
               `OP_RTYPE:
                  case (ctrl.funct)
                     `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND,
                     `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU:
                        nextState = stExR;
                     default: prepFetch = 1'b1;
                  endcase
               `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
               `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
                  nextState = stExI;
               `OP_LW:           nextState = stLw1;
               `OP_SW:           nextState = stSw1;
               `OP_BEQ, `OP_BNE: nextState = stBra1;
               `OP_J:            nextState = stJump;
               default:          prepFetch = 1'b1;   // Unsupported acts as no-op
            endcase
         end
         stExR: begin
            ctrl.aluOp   = rTypeOp(ctrl.funct);
            ctrl.regDst  = dstRd;
            ctrl.rfWrite = 1'b1;
            prepFetch    = 1'b1;
         end
         stExI: begin
            ctrl.aluSelB = aluBImm;
            ctrl.rfWrite = 1'b1;
            prepFetch    = 1'b1;
            case (ctrl.opcode)
               `OP_ADDIU: ctrl.aluOp = aluAddu;
               `OP_SLTI:  ctrl.aluOp = aluSlt;
               `OP_SLTIU: ctrl.aluOp = aluSltu;
               `OP_ANDI: begin
                  ctrl.aluOp   = aluAnd;
                  ctrl.signExt = 1'b0;
               end
               `OP_ORI: begin
                  ctrl.aluOp   = aluOr;
                  ctrl.signExt = 1'b0;
               end
               `OP_XORI: begin
                  ctrl.aluOp   = aluXor;
                  ctrl.signExt = 1'b0;
               end
               `OP_LUI: begin
                  ctrl.aluOp   = aluLui;
                  ctrl.signExt = 1'b0;
               end
               default: ctrl.aluOp = aluAdd;
            endcase
         end
         stLw1: begin   // Address into MAR, start read
            ctrl.aluSelB    = aluBImm;
            ctrl.addrSrc    = addrAlu;
            ctrl.marWrite   = 1'b1;
            ctrl.setMemRead = 1'b1;
            nextState       = stLw2;
         end
         stLw2: nextState = stLw3;
         stLw3: begin
            ctrl.mdrWrite   = 1'b1;
            ctrl.clrMemRead = 1'b1;
            nextState       = stLw4;
         end
         stLw4: begin
            ctrl.wbSrc   = wbMdr;
            ctrl.rfWrite = 1'b1;
            prepFetch    = 1'b1;
         end
         stSw1: begin
            ctrl.aluSelB  = aluBImm;
            ctrl.addrSrc  = addrAlu;
            ctrl.marWrite = 1'b1;
            nextState     = stSw2;
         end
         stSw2: begin
            ctrl.setMemWrite = 1'b1;
            nextState        = stSw3;
         end
         stSw3: prepFetch = 1'b1;
         stBra1: begin
            ctrl.aluOp = aluSub;
            if (ctrl.aluZero ^ ctrl.opcode[0])   // beq on zero, bne on nonzero
               nextState = stBra2;
            else
               prepFetch = 1'b1;
         end
         stBra2: begin   // PC + 4 already in PC
            ctrl.aluSelA    = aluAPc;
            ctrl.aluSelB    = aluBImmSh;
            ctrl.pcWrite    = 1'b1;
            ctrl.addrSrc    = addrAlu;
            ctrl.marWrite   = 1'b1;
            ctrl.setMemRead = 1'b1;
            nextState       = stFetch1;
         end
         stJump: begin
            ctrl.pcWrite    = 1'b1;
            ctrl.pcSrc      = pcJump;
            ctrl.addrSrc    = addrJump;
            ctrl.marWrite   = 1'b1;
            ctrl.setMemRead = 1'b1;
            nextState       = stFetch1;
         end
         default: prepFetch = 1'b1;   // stReset
      endcase

      // Next fetch from the PC
      if (prepFetch) begin
         ctrl.addrSrc    = addrPc;
         ctrl.marWrite   = 1'b1;
         ctrl.setMemRead = 1'b1;
         nextState       = stFetch1;
      end
   end

endmodule

/* source/mipsCore.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module mipsCore (
   input  logic                   clk,
   input  logic                   reset,
   output logic [`DATA_WIDTH-1:0] memAddr,
   input  logic [`DATA_WIDTH-1:0] memReadData,
   output logic [`DATA_WIDTH-1:0] memWriteData,
   output logic                   memRead,
   output logic                   memWrite
);

   ctrlIf ctrlBus ();

   mipsController u_controller (
      .clk   (clk),
      .reset (reset),
      .ctrl  (ctrlBus.controller)
   );

   // Memory side of the core
   mipsDatapath u_datapath (
      .clk          (clk),
      .reset        (reset),
      .ctrl         (ctrlBus.datapath),
      .memAddr      (memAddr),
      .memReadData  (memReadData),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

endmodule

/* verification/mipsTbTable.svh */
`ifndef MIPSTBTABLE_SVH
`define MIPSTBTABLE_SVH

`include "mipsCore_defs.svh"

localparam logic [31:0] StoreBase  = 32'h0000_0100;   // Held in r1
localparam logic [31:0] DataAddr   = 32'h0000_0200;   // Word read by lw
localparam int          SkipOffset = 'hF0;            // Store on the skipped path
localparam logic [31:0] ValA       = 32'h8000_0000;   // r2
localparam logic [31:0] ValB       = 32'h1234_5678;   // r3
localparam logic [31:0] ValC       = 32'hFFFF_FF00;   // r10

logic [31:0] progImage [$];   // Instruction words from address zero
logic [31:0] storeAddr [$];   // Expected stores in program order
logic [31:0] storeData [$];

function automatic logic [31:0] boolWord(input logic cond);
   return cond ? 32'd1 : 32'd0;
endfunction

// sw of rt to the next slot and the value it must carry
task automatic storeReg(input int rt, input logic [31:0] value);
   int offset;
   offset = storeAddr.size() * 4;
   progImage.push_back(encodeI(`OP_SW, 1, rt, offset));
   storeAddr.push_back(StoreBase + offset);
   storeData.push_back(value);
endtask

task automatic buildTables(input logic [31:0] lwData);
   // ==================================================
   // Operands and R-type
   // ==================================================
   progImage.push_back(encodeI(`OP_ADDIU, 0, 1, StoreBase));
   progImage.push_back(encodeI(`OP_LUI, 0, 2, 'h8000));
   progImage.push_back(encodeI(`OP_LUI, 0, 3, 'h1234));
   progImage.push_back(encodeI(`OP_ORI, 3, 3, 'h5678));
   progImage.push_back(encodeI(`OP_ADDI, 0, 10, -256));
   progImage.push_back(encodeR(`FN_ADD, 2, 3, 4));
   progImage.push_back(encodeR(`FN_ADDU, 3, 3, 5));
   progImage.push_back(encodeR(`FN_SUB, 2, 3, 6));
   progImage.push_back(encodeR(`FN_SUBU, 3, 2, 7));
   progImage.push_back(encodeR(`FN_AND, 3, 10, 8));
   progImage.push_back(encodeR(`FN_OR, 2, 3, 9));
   progImage.push_back(encodeR(`FN_XOR, 3, 10, 11));
   progImage.push_back(encodeR(`FN_NOR, 3, 10, 12));
   progImage.push_back(encodeR(`FN_SLT, 2, 3, 13));   // Subtraction overflows here
   progImage.push_back(encodeR(`FN_SLTU, 2, 3, 14));
   progImage.push_back(encodeR(`FN_ADD, 2, 3, 0));
   storeReg(4, ValA + ValB);
   storeReg(5, ValB + ValB);
   storeReg(6, ValA - ValB);
   storeReg(7, ValB - ValA);
   storeReg(8, ValB & ValC);
   storeReg(9, ValA | ValB);
   storeReg(11, ValB ^ ValC);
   storeReg(12, ~(ValB | ValC));
   storeReg(13, boolWord($signed(ValA) < $signed(ValB)));
   storeReg(14, boolWord(ValA < ValB));
   storeReg(0, 32'h0000_0000);
   storeReg(2, ValA);
   storeReg(3, ValB);
   storeReg(10, ValC);

   // I-type with sign extension except for the logical ones
   progImage.push_back(encodeI(`OP_ADDIU, 3, 16, 'h8000));
   progImage.push_back(encodeI(`OP_SLTI, 10, 17, -1));
   progImage.push_back(encodeI(`OP_SLTIU, 3, 18, -1));
   progImage.push_back(encodeI(`OP_ANDI, 10, 19, 'h8F0F));
   progImage.push_back(encodeI(`OP_ORI, 0, 20, 'h8001));
   progImage.push_back(encodeI(`OP_XORI, 10, 21, 'hFFFF));
   storeReg(16, ValB + 32'hFFFF_8000);
   storeReg(17, boolWord($signed(ValC) < -1));
   storeReg(18, boolWord(ValB < 32'hFFFF_FFFF));
   storeReg(19, ValC & 32'h0000_8F0F);
   storeReg(20, 32'h0000_8001);
   storeReg(21, ValC ^ 32'h0000_FFFF);

   progImage.push_back(encodeI(`OP_LW, 0, 22, DataAddr));
   storeReg(22, lwData);

   // ==================================================
   // Branches and the final jump
   // ==================================================
   progImage.push_back(encodeI(`OP_BEQ, 2, 2, 1));   // Taken
   progImage.push_back(encodeI(`OP_SW, 1, 3, SkipOffset));
   storeReg(3, ValB);
   progImage.push_back(encodeI(`OP_BNE, 3, 3, 1));   // Not taken
   storeReg(5, ValB + ValB);
   progImage.push_back(encodeJ(`OP_J, progImage.size()));
endtask

`endif

/* verification/mipsCoreTb.sv */
`timescale 1ns/10ps
`include "mipsCore_defs.svh"

module mipsCoreTb;

   localparam int          ResetCycles  = 5;
   localparam int          MemWords     = 1024;
   localparam int          FetchTimeout = 20;
   localparam int          StoreTimeout = 200;
   localparam int          IdleCycles   = 200;
   localparam logic [31:0] RandSeed     = 32'ha5bfb2dc;

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   logic [31:0] memAddr;
   logic [31:0] memReadData = '0;
   logic [31:0] memWriteData;
   logic        memRead;
   logic        memWrite;

   logic [31:0] mem [MemWords];
   logic [31:0] loadWord;
   logic        prevWrite = 1'b0;

   always #4 clk = ~clk;

   mipsCore u_mipsCore (
      .clk          (clk),
      .reset        (reset),
      .memAddr      (memAddr),
      .memReadData  (memReadData),
      .memWriteData (memWriteData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   // ==================================================
   // Instruction encoders
   // ==================================================
   function automatic logic [31:0] encodeR(input logic [5:0] funct, input int rs,
                                           input int rt, input int rd);
      return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
   endfunction

   function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs,
                                           input int rt, input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] encodeJ(input logic [5:0] op, input int index);
      return {op, index[25:0]};
   endfunction

   `include "mipsTbTable.svh"

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expected,
                  actual);
         $display("TEST FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic waitForFetch();
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         checkValue(32'(memWrite), 32'd0, "memWrite before first fetch");
      end while (!memRead && cycles < FetchTimeout);
      if (!memRead) begin
         $display("Timeout at %0t ns: memRead never rose after reset", $time);
         $display("TEST FAILED");
         $fatal(1, "Fetch timeout");
      end
   endtask

   task automatic waitForStore(input int entry);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!memWrite && cycles < StoreTimeout);
      if (!memWrite) begin
         $display("Timeout at %0t ns: no store arrived for entry %0d", $time, entry);
         $display("TEST FAILED");
         $fatal(1, "Store timeout");
      end
   endtask

   // Memory model with read data one cycle after memRead
   always @(posedge clk) begin
      if (memRead)
         memReadData <= mem[memAddr[11:2]];
      if (memWrite)
         mem[memAddr[11:2]] <= memWriteData;
   end

   // Write pulse width and address range
   always @(negedge clk) begin
      if (reset || prevWrite)
         checkValue(32'(memWrite), 32'd0, "memWrite in reset or past one cycle");
      if ((memRead || memWrite) && memAddr[31:12] != '0) begin
         $display("Memory access at %0t ns falls outside the model: %h", $time, memAddr);
         $display("TEST FAILED");
         $fatal(1, "Address out of range");
      end
      prevWrite = memWrite;
   end

   initial begin
      void'($urandom(RandSeed));
      loadWord = $urandom();
      buildTables(loadWord);
      for (int i = 0; i < MemWords; i++)
         mem[i] = (i * 4) ^ 32'hDEAD_BEEF;   // Distinct per address
      foreach (progImage[i])
         mem[i] = progImage[i];
      mem[DataAddr[11:2]] = loadWord;

      repeat (ResetCycles) @(posedge clk);
      reset <= 1'b0;

      waitForFetch();
      checkValue(memAddr, `RESET_VECTOR, "first fetch address");

      foreach (storeAddr[entry]) begin
         waitForStore(entry);
         checkValue(memAddr, storeAddr[entry], $sformatf("store %0d address", entry));
         checkValue(memWriteData, storeData[entry], $sformatf("store %0d data", entry));
      end

      // Core now spins on its final jump
      repeat (IdleCycles) begin
         @(negedge clk);
         checkValue(32'(memWrite), 32'd0, "store after final jump");
      end

      $display("TEST OK");
      $finish;
   end

endmodule

/* mipsCore.f */
+incdir+source
+incdir+verification
source/mipsPkg.sv
source/ctrlIf.sv
source/mipsAlu.sv
source/regFile.sv
source/mipsDatapath.sv
source/mipsController.sv
source/mipsCore.sv
verification/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module mipsCoreTb \
   -f mipsCore.f --Mdir obj_dir -o mipsCoreSim > compile.log 2>&1
if [ $? -ne 0 ]; then
   cat compile.log
   echo "Compile failed, see compile.log"
   exit 1
fi

./obj_dir/mipsCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -qx "TEST OK" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
